//--- common/shade_defines.svh
`ifndef SHADE_DEFINES_SVH
`define SHADE_DEFINES_SVH

// fixed-point word, signed Q8.8
`define FIX_W     16
`define FIX_FRAC  8

// point light location in Q8.8 (0, 7, 7)
`define LIGHT_X   16'sh0000
`define LIGHT_Y   16'sh0700
`define LIGHT_Z   16'sh0700

// byte per colour channel
`define COLOR_W   8

`define SPHERE_R  8'd0
`define SPHERE_G  8'd255
`define SPHERE_B  8'd0

`define CYL_R     8'd255
`define CYL_G     8'd255
`define CYL_B     8'd255

// dot product is divided by 2**DOT_SHIFT before colouring
`define DOT_SHIFT 4

`endif

//--- common/fix_pkg.sv
`include "shade_defines.svh"

package fix_pkg;

  typedef logic signed [`FIX_W-1:0] fix_t;
  typedef fix_t [2:0] fix_vec_t;                   // [0] x, [1] y, [2] z

  // a full product and the sum of three of them
  typedef logic signed [2*`FIX_W-1:0] fix_prod_t;
  typedef logic signed [2*`FIX_W+1:0] fix_wide_t;

  localparam fix_t FIX_MAX = {1'b0, {(`FIX_W-1){1'b1}}};
  localparam fix_t FIX_MIN = {1'b1, {(`FIX_W-1){1'b0}}};

  // product of two Q8.8 words, brought back to Q8.8 scale
  function automatic fix_prod_t fix_mul(fix_t a, fix_t b);
    return fix_prod_t'(a) * fix_prod_t'(b) >>> `FIX_FRAC;
  endfunction

  function automatic fix_t fix_sat(fix_wide_t v);
    if (v > fix_wide_t'(FIX_MAX))
      return FIX_MAX;
    else if (v < fix_wide_t'(FIX_MIN))
      return FIX_MIN;
    else
      return v[`FIX_W-1:0];
  endfunction

endpackage

//--- common/shade_pkg.sv
`include "shade_defines.svh"

package shade_pkg;

  typedef enum logic {
    SHAPE_SPHERE   = 1'b0,
    SHAPE_CYLINDER = 1'b1
  } shape_e;

  typedef logic [`COLOR_W-1:0] color_t;

  // red sits in the top byte of the pixel word
  typedef struct packed {
    color_t r;
    color_t g;
    color_t b;
  } rgb_t;

  typedef union packed {
    logic [3*`COLOR_W-1:0] raw;
    rgb_t                  rgb;
  } pixel_u;

  // unsigned colour times signed scaled dot, still carrying the Q8.8 fraction
  typedef logic signed [`FIX_W+`COLOR_W:0] chan_t;

  localparam chan_t CHAN_MAX = (1 << `COLOR_W) - 1;

endpackage

//--- common/dot_stream_if.sv
`timescale 1ns/1ps

// one dot product with its shape flag, valid/ready handshake
interface dot_stream_if
  import fix_pkg::*, shade_pkg::*;
  ();

  fix_t   dot;
  shape_e shape;
  logic   valid;
  logic   ready;

  modport src (
    output dot,
    output shape,
    output valid,
    input  ready
  );

  modport dst (
    input  dot,
    input  shape,
    input  valid,
    output ready
  );

endinterface

//--- shade/light_dot.sv
`timescale 1ns/1ps
`include "shade_defines.svh"

module light_dot
  import fix_pkg::*, shade_pkg::*;
(
  input  logic             aclk,
  input  logic             arst_n,
  input  fix_vec_t         hit_tdata,
  input  logic             hit_tvalid,
  output logic             hit_tready,
  input  fix_vec_t         normal_tdata,
  input  shape_e           normal_tuser,
  input  logic             normal_tvalid,
  output logic             normal_tready,
  dot_stream_if.src        out
);

  localparam fix_vec_t LIGHT = {`LIGHT_Z, `LIGHT_Y, `LIGHT_X};

  logic      join_ok;

  logic      s1_valid;
  logic      s1_ready;
  fix_vec_t  s1_dir;
  fix_vec_t  s1_nrm;
  shape_e    s1_shape;

  logic      s2_valid;
  logic      s2_ready;
  fix_prod_t s2_prod [3];
  shape_e    s2_shape;

  logic      s3_valid;
  logic      s3_ready;
  fix_t      s3_dot;
  shape_e    s3_shape;

  fix_wide_t sum;

  assign s3_ready = !s3_valid || out.ready;
  assign s2_ready = !s2_valid || s3_ready;
  assign s1_ready = !s1_valid || s2_ready;

  // both streams move together, so pairs stay matched in arrival order
  assign join_ok       = hit_tvalid && normal_tvalid && s1_ready;
  assign hit_tready    = join_ok;
  assign normal_tready = join_ok;

  always_ff @(posedge aclk or negedge arst_n) begin
    if (!arst_n) begin
      s1_valid <= 1'b0;
      s2_valid <= 1'b0;
      s3_valid <= 1'b0;
    end else begin
      if (s1_ready) s1_valid <= join_ok;
      if (s2_ready) s2_valid <= s1_valid;
      if (s3_ready) s3_valid <= s2_valid;
    end
  end

  // the sum keeps full width, saturation happens only once at the end
  assign sum = fix_wide_t'(s2_prod[0]) + fix_wide_t'(s2_prod[1]) + fix_wide_t'(s2_prod[2]);

  always_ff @(posedge aclk) begin
    if (join_ok) begin
      for (int i = 0; i < 3; i++) begin
        s1_dir[i] <= LIGHT[i] - hit_tdata[i];  // wraps at fix_t width
      end
      s1_nrm   <= normal_tdata;
      s1_shape <= normal_tuser;
    end
    if (s1_valid && s2_ready) begin
      for (int i = 0; i < 3; i++) begin
        s2_prod[i] <= fix_mul(s1_dir[i], s1_nrm[i]);
      end
      s2_shape <= s1_shape;
    end
    if (s2_valid && s3_ready) begin
      s3_dot   <= fix_sat(sum);
      s3_shape <= s2_shape;
    end
  end

  assign out.dot   = s3_dot;
  assign out.shape = s3_shape;
  assign out.valid = s3_valid;

  // a stalled result must reach color_scale unchanged
  a_out_hold: assert property (@(posedge aclk) disable iff (!arst_n)
    out.valid && !out.ready |=> out.valid && $stable(out.dot) && $stable(out.shape));

  a_out_rst: assert property (@(posedge aclk) !arst_n |-> !out.valid);

endmodule

//--- shade/color_scale.sv
`timescale 1ns/1ps
`include "shade_defines.svh"

module color_scale
  import fix_pkg::*, shade_pkg::*;
(
  input  logic      aclk,
  input  logic      arst_n,
  dot_stream_if.dst in,
  output chan_t     ch_r,
  output chan_t     ch_g,
  output chan_t     ch_b,
  output logic      ch_valid,
  input  logic      ch_ready
);

  localparam rgb_t SPHERE_COLOR = {`SPHERE_R, `SPHERE_G, `SPHERE_B};
  localparam rgb_t CYL_COLOR    = {`CYL_R, `CYL_G, `CYL_B};

  logic stage_ready;
  fix_t scaled;
  rgb_t color;

  // colour byte is unsigned, widen with a zero sign bit before the product
  function automatic chan_t chan_mul(color_t c, fix_t s);
    return chan_t'($signed({1'b0, c})) * chan_t'(s);
  endfunction

  assign stage_ready = !ch_valid || ch_ready;
  assign in.ready    = stage_ready;

  assign scaled = in.dot >>> `DOT_SHIFT;   // divide by sixteen, rounds toward minus infinity
  assign color  = (in.shape == SHAPE_CYLINDER) ? CYL_COLOR : SPHERE_COLOR;

  always_ff @(posedge aclk or negedge arst_n) begin
    if (!arst_n) begin
      ch_valid <= 1'b0;
    end else if (stage_ready) begin
      ch_valid <= in.valid;
    end
  end

  // the FIX_FRAC shift is left to pixel_pack
  always_ff @(posedge aclk) begin
    if (in.valid && stage_ready) begin
      ch_r <= chan_mul(color.r, scaled);
      ch_g <= chan_mul(color.g, scaled);
      ch_b <= chan_mul(color.b, scaled);
    end
  end

  a_ch_hold: assert property (@(posedge aclk) disable iff (!arst_n)
    ch_valid && !ch_ready |=> ch_valid && $stable(ch_r) && $stable(ch_g) && $stable(ch_b));

endmodule

//--- shade/pixel_pack.sv
`timescale 1ns/1ps
`include "shade_defines.svh"

module pixel_pack
  import shade_pkg::*;
(
  input  logic   aclk,
  input  logic   arst_n,
  input  chan_t  ch_r,
  input  chan_t  ch_g,
  input  chan_t  ch_b,
  input  logic   ch_valid,
  output logic   ch_ready,
  output pixel_u pixel,
  output logic   pixel_valid,
  input  logic   pixel_ready
);

  logic   stage_ready;
  pixel_u pix_d;

  // drop the fraction and saturate into one byte
  function automatic color_t clamp_chan(chan_t c);
    chan_t s;
    s = c >>> `FIX_FRAC;
    if (s < 0)
      return '0;
    else if (s > CHAN_MAX)
      return CHAN_MAX[`COLOR_W-1:0];
    else
      return s[`COLOR_W-1:0];
  endfunction

  assign stage_ready = !pixel_valid || pixel_ready;
  assign ch_ready    = stage_ready;

  always_comb begin
    pix_d.rgb.r = clamp_chan(ch_r);
    pix_d.rgb.g = clamp_chan(ch_g);
    pix_d.rgb.b = clamp_chan(ch_b);
  end

  always_ff @(posedge aclk or negedge arst_n) begin
    if (!arst_n) begin
      pixel_valid <= 1'b0;
    end else if (stage_ready) begin
      pixel_valid <= ch_valid;
    end
  end

  always_ff @(posedge aclk) begin
    if (ch_valid && stage_ready) begin
      pixel <= pix_d;
    end
  end

  a_pix_rst: assert property (@(posedge aclk) !arst_n |-> !pixel_valid);

endmodule

//--- hw/lambert_shade.sv
`timescale 1ns/1ps

module lambert_shade
  import fix_pkg::*, shade_pkg::*;
(
  input  logic                      aclk,
  input  logic                      arst_n,
  input  fix_vec_t                  hit_tdata,
  input  logic                      hit_tvalid,
  output logic                      hit_tready,
  input  fix_vec_t                  normal_tdata,
  input  shape_e                    normal_tuser,
  input  logic                      normal_tvalid,
  output logic                      normal_tready,
  output logic [$bits(pixel_u)-1:0] pixel_tdata,
  output logic                      pixel_tvalid,
  input  logic                      pixel_tready
);

  dot_stream_if dot_link ();

  chan_t  ch_r;
  chan_t  ch_g;
  chan_t  ch_b;
  logic   ch_valid;
  logic   ch_ready;
  pixel_u pixel;

  light_dot light_dot0 (
    .aclk          (aclk),
    .arst_n        (arst_n),
    .hit_tdata     (hit_tdata),
    .hit_tvalid    (hit_tvalid),
    .hit_tready    (hit_tready),
    .normal_tdata  (normal_tdata),
    .normal_tuser  (normal_tuser),
    .normal_tvalid (normal_tvalid),
    .normal_tready (normal_tready),
    .out           (dot_link.src)
  );

  color_scale color_scale0 (
    .aclk     (aclk),
    .arst_n   (arst_n),
    .in       (dot_link.dst),
    .ch_r     (ch_r),
    .ch_g     (ch_g),
    .ch_b     (ch_b),
    .ch_valid (ch_valid),
    .ch_ready (ch_ready)
  );

  pixel_pack pixel_pack0 (
    .aclk        (aclk),
    .arst_n      (arst_n),
    .ch_r        (ch_r),
    .ch_g        (ch_g),
    .ch_b        (ch_b),
    .ch_valid    (ch_valid),
    .ch_ready    (ch_ready),
    .pixel       (pixel),
    .pixel_valid (pixel_tvalid),
    .pixel_ready (pixel_tready)
  );

  assign pixel_tdata = pixel.raw;  // red in bits 23:16

endmodule

//--- test/lambert_checker.sv
`timescale 1ns/1ps

module lambert_checker (
  input  logic        aclk,
  input  logic        arst_n,
  input  logic        hit_tvalid,
  input  logic        hit_tready,
  input  logic        normal_tvalid,
  input  logic        normal_tready,
  input  logic [23:0] exp_pixel,
  input  logic [23:0] pixel_tdata,
  input  logic        pixel_tvalid,
  input  logic        pixel_tready,
  output int          err_count,
  output int          checked,
  output int          queued
);

  logic [23:0] exp_q [$];  // expected pixels in arrival order
  int          accepted;

  initial begin
    err_count = 0;
    checked   = 0;
    queued    = 0;
    accepted  = 0;
  end

  always @(posedge aclk) begin
    logic [23:0] want;
    if (!arst_n) begin
      if (pixel_tvalid) begin
        err_count++;
        $display("error at %0t: pixel_tvalid is high during reset", $time);
      end
    end else begin
      // the join moves both streams in the same cycle
      if (hit_tready != normal_tready) begin
        err_count++;
        $display("error at %0t: hit_tready and normal_tready differ", $time);
      end
      if (hit_tready && !(hit_tvalid && normal_tvalid)) begin
        err_count++;
        $display("error at %0t: input ready is high without both valids", $time);
      end
      if (pixel_tvalid && accepted == 0) begin
        err_count++;
        $display("error at %0t: pixel_tvalid rose before any pair was accepted", $time);
      end
      if (hit_tvalid && hit_tready) begin
        exp_q.push_back(exp_pixel);
        accepted++;
      end
      if (pixel_tvalid && pixel_tready) begin
        if (exp_q.size() == 0) begin
          err_count++;
          $display("error at %0t: a pixel came out with no pair pending", $time);
        end else begin
          want = exp_q.pop_front();
          checked++;
          if (pixel_tdata !== want) begin
            err_count++;
            $display("mismatch at %0t: pixel_tdata got %06h, expected %06h",
                     $time, pixel_tdata, want);
          end
        end
      end
    end
    queued = exp_q.size();
  end

endmodule

//--- test/tb_lambert_top.sv
`timescale 1ns/1ps
`include "shade_defines.svh"

module tb_lambert_top
  import fix_pkg::*, shade_pkg::*;
  ();

  localparam int N_PAIRS     = 200;
  localparam int WAIT_LIMIT  = 100;
  localparam int DRAIN_LIMIT = 400;
  localparam int RDY_LEN     = 256;

  logic        aclk;
  logic        arst_n;
  fix_vec_t    hit_tdata;
  logic        hit_tvalid;
  logic        hit_tready;
  fix_vec_t    normal_tdata;
  shape_e      normal_tuser;
  logic        normal_tvalid;
  logic        normal_tready;
  logic [23:0] pixel_tdata;
  logic        pixel_tvalid;
  logic        pixel_tready;

  logic [23:0] exp_pixel;
  int          err_count;
  int          checked;
  int          queued;
  integer      seed = 32'h3edd;
  bit          stuck;
  int          rdy_idx;

  fix_vec_t hit_arr [N_PAIRS];
  fix_vec_t nrm_arr [N_PAIRS];
  shape_e   shp_arr [N_PAIRS];
  int       hit_gap [N_PAIRS];
  int       nrm_gap [N_PAIRS];
  bit       rdy_pat [RDY_LEN];

  lambert_shade dut0 (
    .aclk          (aclk),
    .arst_n        (arst_n),
    .hit_tdata     (hit_tdata),
    .hit_tvalid    (hit_tvalid),
    .hit_tready    (hit_tready),
    .normal_tdata  (normal_tdata),
    .normal_tuser  (normal_tuser),
    .normal_tvalid (normal_tvalid),
    .normal_tready (normal_tready),
    .pixel_tdata   (pixel_tdata),
    .pixel_tvalid  (pixel_tvalid),
    .pixel_tready  (pixel_tready)
  );

  lambert_checker chk0 (
    .aclk          (aclk),
    .arst_n        (arst_n),
    .hit_tvalid    (hit_tvalid),
    .hit_tready    (hit_tready),
    .normal_tvalid (normal_tvalid),
    .normal_tready (normal_tready),
    .exp_pixel     (exp_pixel),
    .pixel_tdata   (pixel_tdata),
    .pixel_tvalid  (pixel_tvalid),
    .pixel_tready  (pixel_tready),
    .err_count     (err_count),
    .checked       (checked),
    .queued        (queued)
  );

  always #50 aclk = ~aclk;

  function automatic fix_vec_t make_vec(input int x, input int y, input int z);
    fix_vec_t v;
    v[0] = fix_t'(x);
    v[1] = fix_t'(y);
    v[2] = fix_t'(z);
    return v;
  endfunction

  // uniform in -lim..lim, in Q8.8 steps
  function automatic fix_t pick_fix(input int lim);
    return fix_t'($random(seed) % (lim + 1));
  endfunction

  // reference model of the shading rule, in plain integers
  function automatic logic [23:0] expect_pixel(fix_vec_t hit, fix_vec_t nrm, shape_e shape);
    longint light [3];
    longint colour [3];
    longint lim;
    longint sum;
    longint dot;
    longint scaled;
    longint ch;
    logic [23:0] pix;
    light[0] = `LIGHT_X;
    light[1] = `LIGHT_Y;
    light[2] = `LIGHT_Z;
    if (shape == SHAPE_CYLINDER) begin
      colour[0] = `CYL_R;
      colour[1] = `CYL_G;
      colour[2] = `CYL_B;
    end else begin
      colour[0] = `SPHERE_R;
      colour[1] = `SPHERE_G;
      colour[2] = `SPHERE_B;
    end
    sum = 0;
    for (int i = 0; i < 3; i++) begin
      sum += ((light[i] - longint'(hit[i])) * longint'(nrm[i])) >>> `FIX_FRAC;
    end
    lim = longint'(1) << (`FIX_W - 1);
    dot = (sum > lim - 1) ? lim - 1 : (sum < -lim) ? -lim : sum;
    scaled = dot >>> `DOT_SHIFT;
    for (int c = 0; c < 3; c++) begin
      ch = (colour[c] * scaled) >>> `FIX_FRAC;
      if (ch < 0)
        ch = 0;
      else if (ch > 255)
        ch = 255;
      pix[23 - 8*c -: 8] = ch[7:0];  // red lands in the top byte
    end
    return pix;
  endfunction

  assign exp_pixel = expect_pixel(hit_tdata, normal_tdata, normal_tuser);

  task automatic fill_stimulus();
    bit big;
    // a few fixed pairs first: dim green, dim grey, facing away, saturated
    hit_arr[0] = make_vec(0, 0, 0);
    nrm_arr[0] = make_vec(0, 32, 0);
    shp_arr[0] = SHAPE_SPHERE;
    hit_arr[1] = make_vec(0, 0, 0);
    nrm_arr[1] = make_vec(0, 32, 0);
    shp_arr[1] = SHAPE_CYLINDER;
    hit_arr[2] = make_vec(0, 0, 0);
    nrm_arr[2] = make_vec(0, -256, -256);
    shp_arr[2] = SHAPE_SPHERE;
    hit_arr[3] = make_vec(0, 0, 0);
    nrm_arr[3] = make_vec(0, 4096, 4096);
    shp_arr[3] = SHAPE_CYLINDER;
    for (int i = 4; i < N_PAIRS; i++) begin
      big = ($random(seed) % 3) == 0;
      hit_arr[i] = {pick_fix(2048), pick_fix(2048), pick_fix(2048)};
      nrm_arr[i] = big ? {pick_fix(4096), pick_fix(4096), pick_fix(4096)}
                       : {pick_fix(256), pick_fix(256), pick_fix(256)};
      shp_arr[i] = ($random(seed) & 1) ? SHAPE_CYLINDER : SHAPE_SPHERE;
    end
    for (int i = 0; i < N_PAIRS; i++) begin
      hit_gap[i] = {$random(seed)} % 4;
      nrm_gap[i] = {$random(seed)} % 4;
    end
    for (int i = 0; i < RDY_LEN; i++) begin
      rdy_pat[i] = ({$random(seed)} % 4) != 0;
    end
  endtask

  task automatic wait_accept(input bit hit_side);
    int cycles;
    bit taken;
    cycles = 0;
    taken  = 1'b0;
    while (!taken && cycles < WAIT_LIMIT) begin
      @(posedge aclk);
      cycles++;
      taken = hit_side ? hit_tready : normal_tready;
    end
    if (!taken) begin
      stuck = 1'b1;
      $display("timeout at %0t: the %s stream was not accepted", $time,
               hit_side ? "hit" : "normal");
    end
  endtask

  task automatic drive_hits();
    for (int i = 0; i < N_PAIRS && !stuck; i++) begin
      repeat (hit_gap[i]) @(negedge aclk);
      hit_tdata  = hit_arr[i];
      hit_tvalid = 1'b1;
      wait_accept(1'b1);
      @(negedge aclk);
      hit_tvalid = 1'b0;
    end
  endtask

  task automatic drive_normals();
    for (int i = 0; i < N_PAIRS && !stuck; i++) begin
      repeat (nrm_gap[i]) @(negedge aclk);
      normal_tdata  = nrm_arr[i];
      normal_tuser  = shp_arr[i];
      normal_tvalid = 1'b1;
      wait_accept(1'b0);
      @(negedge aclk);
      normal_tvalid = 1'b0;
    end
  endtask

  always @(negedge aclk) begin
    pixel_tready = rdy_pat[rdy_idx];
    rdy_idx      = (rdy_idx + 1) % RDY_LEN;
  end

  initial begin
    int cycles;
    aclk          = 1'b0;
    arst_n        = 1'b0;
    hit_tdata     = '0;
    hit_tvalid    = 1'b0;
    normal_tdata  = '0;
    normal_tuser  = SHAPE_SPHERE;
    normal_tvalid = 1'b0;
    pixel_tready  = 1'b0;
    stuck         = 1'b0;
    rdy_idx       = 0;
    fill_stimulus();
    repeat (16) @(posedge aclk);
    @(negedge aclk);
    arst_n = 1'b1;
    fork
      drive_hits();
      drive_normals();
    join
    cycles = 0;
    while (!stuck && checked < N_PAIRS && cycles < DRAIN_LIMIT) begin
      @(negedge aclk);
      cycles++;
    end
    if (!stuck && checked < N_PAIRS) begin
      stuck = 1'b1;
      $display("timeout at %0t: only %0d of %0d pixels came out", $time, checked, N_PAIRS);
    end
    repeat (10) @(negedge aclk);  // catch any extra pixel
    if (queued != 0)
      $display("%0d expected pixels were never produced", queued);
    $display("errors %0d, pixels checked %0d of %0d, timeouts %0d",
             err_count, checked, N_PAIRS, stuck);
    if (err_count == 0 && !stuck && queued == 0 && checked == N_PAIRS) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

//--- project.f
+incdir+common
common/fix_pkg.sv
common/shade_pkg.sv
common/dot_stream_if.sv
shade/light_dot.sv
shade/color_scale.sv
shade/pixel_pack.sv
hw/lambert_shade.sv
test/lambert_checker.sv
test/tb_lambert_top.sv

//--- run_sim.sh
#!/bin/sh
# build and run the lambert_shade testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --timing --assert -Wno-fatal \
    -f project.f --top-module tb_lambert_top \
    -Mdir obj_dir -o sim_lambert; then
  echo "verilator build failed"
  exit 1
fi

if ! ./obj_dir/sim_lambert > "$LOG" 2>&1; then
  cat "$LOG"
  echo "simulation exited with an error"
  exit 1
fi

cat "$LOG"

if grep -q "^TESTBENCH PASSED$" "$LOG"; then
  exit 0
fi
echo "pass message not found in $LOG"
exit 1
